// File: design/elem_counter.sv
// Element issue and retire counters

module elem_counter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  lane_pkg::vl_t       vl_i,
  input  logic                issue_i,
  input  logic                retire_i,
  output lane_pkg::elem_idx_t issue_idx_o,
  output lane_pkg::elem_idx_t retire_idx_o,
  output logic                issue_done_o,
  output logic                retire_done_o
);

  localparam int unsigned IdxW = $bits(lane_pkg::elem_idx_t);

  // Counts run up to vl, one wider than the element index
  lane_pkg::vl_t issue_cnt_q, retire_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_cnt_q  <= '0;
      retire_cnt_q <= '0;
    end else if (start_i) begin
      issue_cnt_q  <= '0;
      retire_cnt_q <= '0;
    end else begin
      if (issue_i) issue_cnt_q <= issue_cnt_q + 1'b1;
      if (retire_i) retire_cnt_q <= retire_cnt_q + 1'b1;
    end
  end

  assign issue_idx_o  = issue_cnt_q[IdxW-1:0];
  assign retire_idx_o = retire_cnt_q[IdxW-1:0];

  // vl of zero is done straight away
  assign issue_done_o  = (issue_cnt_q >= vl_i);
  assign retire_done_o = (retire_cnt_q >= vl_i);

  a_retire_le_issue: assert property (@(posedge clk_i) disable iff (!rst_ni)
    retire_cnt_q <= issue_cnt_q)
    else $error("more elements retired than issued");

endmodule

// File: design/lane_params.svh
// Lane sizing parameters

`ifndef LANE_PARAMS_SVH
`define LANE_PARAMS_SVH

// Element width in bits
`define LANE_ELEM_W 32

// Number of vector registers
`define LANE_NR_VREGS 8

// Elements per vector register
`define LANE_VLMAX 8

// Operand queue entries
`define LANE_FIFO_DEPTH 4

`endif

// File: design/lane_pkg.sv
// Lane shared types

`include "lane_params.svh"

package lane_pkg;

  // One vector element
  typedef logic [`LANE_ELEM_W-1:0] elem_t;

  // Register number and element index
  typedef logic [$clog2(`LANE_NR_VREGS)-1:0] vreg_idx_t;
  typedef logic [$clog2(`LANE_VLMAX)-1:0]    elem_idx_t;

  // Vector length, zero up to VLMAX inclusive
  typedef logic [$clog2(`LANE_VLMAX+1)-1:0] vl_t;

  // Register number in the upper bits, element index below
  typedef logic [$bits(vreg_idx_t)+$bits(elem_idx_t)-1:0] vrf_addr_t;

  typedef enum logic [2:0] {
    ADD = 3'd0,
    SUB = 3'd1,
    AND = 3'd2,
    OR  = 3'd3,
    XOR = 3'd4,
    MIN = 3'd5
  } alu_op_e;

  typedef struct packed {
    elem_t vs1;
    elem_t vs2;
  } operand_pair_t;

  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    ACK  = 2'd2
  } lane_state_e;

endpackage

// File: design/lane_sequencer.sv
// Lane command sequencer

module lane_sequencer (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Command handshake
  input  logic                cmd_req_i,
  input  lane_pkg::alu_op_e   cmd_op_i,
  input  lane_pkg::vreg_idx_t cmd_vd_i,
  input  lane_pkg::vreg_idx_t cmd_vs1_i,
  input  lane_pkg::vreg_idx_t cmd_vs2_i,
  input  lane_pkg::vl_t       cmd_vl_i,
  output logic                cmd_ack_o,
  output logic                busy_o,
  // Operand reads
  vrf_port_if.issuer          vrf,
  input  logic                has_room_i,
  // Element counters
  input  logic                issue_done_i,
  input  logic                retire_done_i,
  output logic                start_o,
  output logic                issue_o,
  input  lane_pkg::elem_idx_t elem_idx_i,
  // Latched command fields
  output lane_pkg::alu_op_e   op_o,
  output lane_pkg::vreg_idx_t vd_o,
  output lane_pkg::vl_t       vl_o
);

  lane_pkg::lane_state_e state_q, state_d;
  logic                  ack_q;

  lane_pkg::alu_op_e     op_q;
  lane_pkg::vreg_idx_t   vd_q, vs1_q, vs2_q;
  lane_pkg::vl_t         vl_q;

  //////////////////////////////////////////////////////////////////////
  // Command FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    start_o = 1'b0;
    case (state_q)
      lane_pkg::IDLE: begin
        if (cmd_req_i) begin
          state_d = lane_pkg::RUN;
          start_o = 1'b1;
        end
      end
      // Hand completion back to the master once the last writeback is seen
      lane_pkg::RUN: if (retire_done_i) state_d = lane_pkg::ACK;
      lane_pkg::ACK: if (!cmd_req_i) state_d = lane_pkg::IDLE;
      default:       state_d = lane_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= lane_pkg::IDLE;
      ack_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_q   <= (state_d == lane_pkg::ACK);
    end
  end

  // Command fields held for the whole run
  always_ff @(posedge clk_i) begin
    if (start_o) begin
      op_q  <= cmd_op_i;
      vd_q  <= cmd_vd_i;
      vs1_q <= cmd_vs1_i;
      vs2_q <= cmd_vs2_i;
      vl_q  <= cmd_vl_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Operand read issue
  //////////////////////////////////////////////////////////////////////

  // One element per cycle while the queue can absorb it
  assign issue_o       = (state_q == lane_pkg::RUN) && has_room_i && !issue_done_i;
  assign vrf.rd_en     = issue_o;
  assign vrf.rd_addr_a = {vs1_q, elem_idx_i};
  assign vrf.rd_addr_b = {vs2_q, elem_idx_i};

  assign cmd_ack_o = ack_q;
  assign busy_o    = (state_q != lane_pkg::IDLE);
  assign op_o      = op_q;
  assign vd_o      = vd_q;
  assign vl_o      = vl_q;

  // Ack marks completion of every element of the command
  a_ack_when_retired: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_ack_o |-> retire_done_i)
    else $error("cmd_ack_o high before all elements were written back");

  // Master must hold req until it has seen ack
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == lane_pkg::RUN) |-> cmd_req_i)
    else $error("cmd_req_i dropped before cmd_ack_o");

endmodule

// File: design/lane_top.sv
// Vector lane top level

module lane_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Command
  input  logic                cmd_req_i,
  input  lane_pkg::alu_op_e   cmd_op_i,
  input  lane_pkg::vreg_idx_t cmd_vd_i,
  input  lane_pkg::vreg_idx_t cmd_vs1_i,
  input  lane_pkg::vreg_idx_t cmd_vs2_i,
  input  lane_pkg::vl_t       cmd_vl_i,
  output logic                cmd_ack_o,
  output logic                busy_o,
  // External register file access
  input  logic                ext_we_i,
  input  lane_pkg::vrf_addr_t ext_addr_i,
  input  lane_pkg::elem_t     ext_wdata_i,
  output lane_pkg::elem_t     ext_rdata_o
);

  vrf_port_if vrf ();

  logic                    has_room, issue_done, retire_done;
  logic                    start, issue, retire;
  lane_pkg::elem_idx_t     issue_idx, retire_idx;
  lane_pkg::alu_op_e       op;
  lane_pkg::vreg_idx_t     vd;
  lane_pkg::vl_t           vl;
  lane_pkg::operand_pair_t rd_pair, pop_data;
  logic                    pop_valid, pop_ready;

  assign rd_pair.vs1 = vrf.rd_data_a;
  assign rd_pair.vs2 = vrf.rd_data_b;

  lane_sequencer i_seq (
    .clk_i, .rst_ni,
    .cmd_req_i, .cmd_op_i, .cmd_vd_i, .cmd_vs1_i, .cmd_vs2_i, .cmd_vl_i,
    .cmd_ack_o, .busy_o,
    .vrf          (vrf.issuer),
    .has_room_i   (has_room),
    .issue_done_i (issue_done),
    .retire_done_i(retire_done),
    .start_o      (start),
    .issue_o      (issue),
    .elem_idx_i   (issue_idx),
    .op_o         (op),
    .vd_o         (vd),
    .vl_o         (vl)
  );

  elem_counter i_cnt (
    .clk_i, .rst_ni,
    .start_i      (start),
    .vl_i         (vl),
    .issue_i      (issue),
    .retire_i     (retire),
    .issue_idx_o  (issue_idx),
    .retire_idx_o (retire_idx),
    .issue_done_o (issue_done),
    .retire_done_o(retire_done)
  );

  vector_regfile i_vrf (
    .clk_i, .rst_ni,
    .vrf(vrf.regfile),
    .ext_we_i, .ext_addr_i, .ext_wdata_i, .ext_rdata_o
  );

  operand_fifo i_opq (
    .clk_i, .rst_ni,
    .push_i     (vrf.rd_valid),
    .push_data_i(rd_pair),
    .pop_valid_o(pop_valid),
    .pop_data_o (pop_data),
    .pop_ready_i(pop_ready),
    .has_room_o (has_room)
  );

  vector_alu i_alu (
    .clk_i, .rst_ni,
    .op_i        (op),
    .vd_i        (vd),
    .retire_idx_i(retire_idx),
    .pop_valid_i (pop_valid),
    .pop_data_i  (pop_data),
    .pop_ready_o (pop_ready),
    .vrf         (vrf.writer),
    .retire_o    (retire)
  );

endmodule

// File: design/operand_fifo.sv
// Operand pair queue

`include "lane_params.svh"

module operand_fifo (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    push_i,
  input  lane_pkg::operand_pair_t push_data_i,
  output logic                    pop_valid_o,
  output lane_pkg::operand_pair_t pop_data_o,
  input  logic                    pop_ready_i,
  output logic                    has_room_o
);

  localparam int unsigned Depth = `LANE_FIFO_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);
  localparam int unsigned CntW  = $clog2(Depth + 1);

  lane_pkg::operand_pair_t mem_q [Depth];
  logic [PtrW-1:0]         wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]         count_q;
  logic                    do_pop;

  assign pop_valid_o = (count_q != '0);
  assign pop_data_o  = mem_q[rd_ptr_q];
  assign do_pop      = pop_valid_o && pop_ready_i;

  // Two free slots, one for the read in flight and one for a new issue
  assign has_room_o = (count_q <= CntW'(Depth - 2));

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= push_data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (count_q != CntW'(Depth)))
    else $error("operand pushed into a full queue");

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_ready_i |-> pop_valid_o)
    else $error("operand popped from an empty queue");

endmodule

// File: design/vector_alu.sv
// Integer element ALU

module vector_alu (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lane_pkg::alu_op_e       op_i,
  input  lane_pkg::vreg_idx_t     vd_i,
  input  lane_pkg::elem_idx_t     retire_idx_i,
  input  logic                    pop_valid_i,
  input  lane_pkg::operand_pair_t pop_data_i,
  output logic                    pop_ready_o,
  vrf_port_if.writer              vrf,
  output logic                    retire_o
);

  lane_pkg::elem_t opa, opb;
  lane_pkg::elem_t result_d, result_q;
  logic            wr_valid_q;

  // Never stalls, so take every valid pair
  assign pop_ready_o = pop_valid_i;

  assign opa = pop_data_i.vs1;
  assign opb = pop_data_i.vs2;

  always_comb begin
    case (op_i)
      lane_pkg::ADD: result_d = opa + opb;
      lane_pkg::SUB: result_d = opa - opb;
      lane_pkg::AND: result_d = opa & opb;
      lane_pkg::OR:  result_d = opa | opb;
      lane_pkg::XOR: result_d = opa ^ opb;
      // Signed compare
      lane_pkg::MIN: result_d = ($signed(opa) < $signed(opb)) ? opa : opb;
      default:       result_d = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (pop_ready_o) result_q <= result_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= pop_ready_o;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Writeback
  //////////////////////////////////////////////////////////////////////

  // Elements retire in order, so the retire count is the element index
  assign vrf.wr_en   = wr_valid_q;
  assign vrf.wr_addr = {vd_i, retire_idx_i};
  assign vrf.wr_data = result_q;
  assign retire_o    = wr_valid_q;

endmodule

// File: design/vector_regfile.sv
// Banked vector register file

`include "lane_params.svh"

module vector_regfile (
  input  logic                clk_i,
  input  logic                rst_ni,
  vrf_port_if.regfile         vrf,
  // External access while the lane is idle
  input  logic                ext_we_i,
  input  lane_pkg::vrf_addr_t ext_addr_i,
  input  lane_pkg::elem_t     ext_wdata_i,
  output lane_pkg::elem_t     ext_rdata_o
);

  localparam int unsigned NrWords   = `LANE_NR_VREGS * `LANE_VLMAX;
  localparam int unsigned BankWords = NrWords / 2;
  localparam int unsigned AddrW     = $bits(lane_pkg::vrf_addr_t);

  // Bank select is address bit 0 and the rest picks the row
  lane_pkg::elem_t bank_q [2][BankWords];

  lane_pkg::elem_t rd_data_a_q, rd_data_b_q, ext_rdata_q;
  logic            rd_valid_q;
  logic            ext_blocked;

  // Lane write wins only when both target the same bank
  assign ext_blocked = vrf.wr_en && (vrf.wr_addr[0] == ext_addr_i[0]);

  always_ff @(posedge clk_i) begin
    if (vrf.wr_en) begin
      bank_q[vrf.wr_addr[0]][vrf.wr_addr[AddrW-1:1]] <= vrf.wr_data;
    end
    if (ext_we_i && !ext_blocked) begin
      bank_q[ext_addr_i[0]][ext_addr_i[AddrW-1:1]] <= ext_wdata_i;
    end
  end

  // Registered reads return old data on a same-cycle write
  always_ff @(posedge clk_i) begin
    if (vrf.rd_en) begin
      rd_data_a_q <= bank_q[vrf.rd_addr_a[0]][vrf.rd_addr_a[AddrW-1:1]];
      rd_data_b_q <= bank_q[vrf.rd_addr_b[0]][vrf.rd_addr_b[AddrW-1:1]];
    end
    ext_rdata_q <= bank_q[ext_addr_i[0]][ext_addr_i[AddrW-1:1]];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= vrf.rd_en;
    end
  end

  assign vrf.rd_data_a = rd_data_a_q;
  assign vrf.rd_data_b = rd_data_b_q;
  assign vrf.rd_valid  = rd_valid_q;
  assign ext_rdata_o   = ext_rdata_q;

  // An operand read never meets the writeback of the same word
  a_no_rd_wr_overlap: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (vrf.rd_en && vrf.wr_en) |->
      (vrf.rd_addr_a != vrf.wr_addr) && (vrf.rd_addr_b != vrf.wr_addr))
    else $error("operand read of a word that is being written back");

endmodule

// File: design/vrf_port_if.sv
// Lane register file port

interface vrf_port_if;

  // Operand reads, two sources per element
  logic                rd_en;
  lane_pkg::vrf_addr_t rd_addr_a;
  lane_pkg::vrf_addr_t rd_addr_b;
  lane_pkg::elem_t     rd_data_a;
  lane_pkg::elem_t     rd_data_b;
  logic                rd_valid;

  // Result writeback
  logic                wr_en;
  lane_pkg::vrf_addr_t wr_addr;
  lane_pkg::elem_t     wr_data;

  modport issuer (
    output rd_en, rd_addr_a, rd_addr_b
  );

  modport regfile (
    input  rd_en, rd_addr_a, rd_addr_b, wr_en, wr_addr, wr_data,
    output rd_data_a, rd_data_b, rd_valid
  );

  modport writer (
    output wr_en, wr_addr, wr_data
  );

endinterface

// File: run.sh
#!/bin/sh
# Build and run the lane testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module lane_tb \
  -Mdir "$BUILD_DIR" -o lane_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/lane_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
  exit 0
fi
echo "Simulation reported failures"
exit 1

// File: sim/lane_tb.sv
// Vector lane testbench

`include "lane_params.svh"

module lane_tb;

  localparam int WaitLimit = 200;
  localparam int VlMax     = `LANE_VLMAX;
  localparam int NrWords   = `LANE_NR_VREGS * `LANE_VLMAX;

  logic                clk_i;
  logic                rst_ni;
  logic                cmd_req_i;
  lane_pkg::alu_op_e   cmd_op_i;
  lane_pkg::vreg_idx_t cmd_vd_i;
  lane_pkg::vreg_idx_t cmd_vs1_i;
  lane_pkg::vreg_idx_t cmd_vs2_i;
  lane_pkg::vl_t       cmd_vl_i;
  logic                cmd_ack_o;
  logic                busy_o;
  logic                ext_we_i;
  lane_pkg::vrf_addr_t ext_addr_i;
  lane_pkg::elem_t     ext_wdata_i;
  lane_pkg::elem_t     ext_rdata_o;

  // Shadow copy of the register file
  lane_pkg::elem_t model [NrWords];
  logic [31:0]     rand_state;
  int              errors;
  int              checks;
  int              tests;
  int              test_errors;

  lane_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Inputs change shortly after the rising edge
  task automatic step();
    @(posedge clk_i);
    #10;
  endtask

  function automatic logic [31:0] next_random();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Element result as the operation defines it
  function automatic lane_pkg::elem_t expected_result(input lane_pkg::alu_op_e op,
                                                      input lane_pkg::elem_t a,
                                                      input lane_pkg::elem_t b);
    case (op)
      lane_pkg::ADD: return a + b;
      lane_pkg::SUB: return a - b;
      lane_pkg::AND: return a & b;
      lane_pkg::OR:  return a | b;
      lane_pkg::XOR: return a ^ b;
      // Flipping the sign bit maps two's complement order onto unsigned order
      lane_pkg::MIN: return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? a : b;
      default:       return 'x;
    endcase
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail at time %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic ext_write(input int addr, input lane_pkg::elem_t data);
    ext_we_i    = 1'b1;
    ext_addr_i  = lane_pkg::vrf_addr_t'(addr);
    ext_wdata_i = data;
    step();
    ext_we_i    = 1'b0;
    model[addr] = data;
  endtask

  // Registered read data is valid one edge after the address
  task automatic ext_read(input int addr, output lane_pkg::elem_t data);
    ext_addr_i = lane_pkg::vrf_addr_t'(addr);
    step();
    data = ext_rdata_o;
  endtask

  task automatic load_vreg(input int vreg);
    for (int e = 0; e < VlMax; e++) begin
      ext_write(vreg * VlMax + e, next_random());
    end
  endtask

  task automatic check_vreg(input int vreg);
    lane_pkg::elem_t got;
    for (int e = 0; e < VlMax; e++) begin
      ext_read(vreg * VlMax + e, got);
      check_value(got, model[vreg * VlMax + e], $sformatf("v%0d[%0d]", vreg, e));
    end
  endtask

  task automatic wait_ack(input logic level, input string what);
    int cycles;
    cycles = 0;
    while (cmd_ack_o !== level && cycles < WaitLimit) begin
      step();
      cycles++;
    end
    if (cmd_ack_o !== level) begin
      errors++;
      $display("Timeout at time %0t: cmd_ack_o never went %0b after %s",
               $time, level, what);
    end
  endtask

  // Full four-phase command before the shadow copy takes the results
  task automatic run_cmd(input lane_pkg::alu_op_e op, input int vd, input int vs1,
                         input int vs2, input int vl, input int hold);
    lane_pkg::elem_t a;
    lane_pkg::elem_t b;
    cmd_op_i  = op;
    cmd_vd_i  = lane_pkg::vreg_idx_t'(vd);
    cmd_vs1_i = lane_pkg::vreg_idx_t'(vs1);
    cmd_vs2_i = lane_pkg::vreg_idx_t'(vs2);
    cmd_vl_i  = lane_pkg::vl_t'(vl);
    cmd_req_i = 1'b1;
    wait_ack(1'b1, "the command was raised");
    repeat (hold) begin
      step();
      check_value({31'b0, cmd_ack_o}, 32'd1, "cmd_ack_o while req is held");
      check_value({31'b0, busy_o}, 32'd1, "busy_o while req is held");
    end
    cmd_req_i = 1'b0;
    wait_ack(1'b0, "req was dropped");
    check_value({31'b0, busy_o}, 32'd0, "busy_o after ack fell");
    for (int i = 0; i < vl; i++) begin
      a = model[vs1 * VlMax + i];
      b = model[vs2 * VlMax + i];
      model[vd * VlMax + i] = expected_result(op, a, b);
    end
  endtask

  task automatic begin_test();
    tests++;
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == test_errors) begin
      $display("Test %0d %s: passed", tests, name);
    end else begin
      $display("Test %0d %s: failed with %0d errors", tests, name, errors - test_errors);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int vd;
    rand_state  = 32'h9dbe_b008;
    errors      = 0;
    checks      = 0;
    tests       = 0;
    test_errors = 0;
    rst_ni      = 1'b0;
    cmd_req_i   = 1'b0;
    cmd_op_i    = lane_pkg::ADD;
    cmd_vd_i    = '0;
    cmd_vs1_i   = '0;
    cmd_vs2_i   = '0;
    cmd_vl_i    = '0;
    ext_we_i    = 1'b0;
    ext_addr_i  = '0;
    ext_wdata_i = '0;
    repeat (16) step();
    rst_ni = 1'b1;
    step();

    begin_test();
    check_value({31'b0, cmd_ack_o}, 32'd0, "cmd_ack_o after reset");
    check_value({31'b0, busy_o}, 32'd0, "busy_o after reset");
    end_test("reset state");

    // Fill every word first so that address decode faults show on readback
    begin_test();
    for (int a = 0; a < NrWords; a++) begin
      ext_write(a, next_random());
    end
    for (int v = 0; v < `LANE_NR_VREGS; v++) begin
      check_vreg(v);
    end
    end_test("external write and readback");

    // Fresh sources for every operation
    begin_test();
    for (int k = 0; k < 6; k++) begin
      vd = 3 + k % 5;
      load_vreg(1);
      load_vreg(2);
      run_cmd(lane_pkg::alu_op_e'(k), vd, 1, 2, VlMax, 0);
      check_vreg(vd);
    end
    end_test("all operations with vl 8");

    begin_test();
    run_cmd(lane_pkg::XOR, 4, 1, 2, 3, 0);
    check_vreg(4);
    run_cmd(lane_pkg::ADD, 5, 1, 2, 0, 0);
    check_vreg(5);
    end_test("short and zero vector length");

    begin_test();
    load_vreg(6);
    run_cmd(lane_pkg::SUB, 6, 6, 1, VlMax, 0);
    check_vreg(6);
    end_test("in-place operation");

    begin_test();
    run_cmd(lane_pkg::MIN, 7, 0, 1, 5, 4);
    check_vreg(7);
    end_test("handshake with held req");

    $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+design
design/lane_pkg.sv
design/vrf_port_if.sv
design/lane_sequencer.sv
design/elem_counter.sv
design/vector_regfile.sv
design/operand_fifo.sv
design/vector_alu.sv
design/lane_top.sv
sim/lane_tb.sv
